/* mul_pkg.sv */
`default_nettype none

package mul_pkg;

    // Width of one operand and of the result word handed back to the pipeline.
    localparam int XLEN = 32;

    // A full product of two XLEN operands.
    localparam int PLEN = 2 * XLEN;

    // Radix-4 Booth gives one row per two multiplier bits. One more row covers
    // the extension digit, so unsigned operands with bit 31 set still come out right.
    localparam int PP_ROWS = XLEN / 2 + 1;

    // Operands and the selected half of the product.
    typedef logic [XLEN-1:0] word_t;

    // Partial products, carry-save rows and the full 64-bit product.
    typedef logic [PLEN-1:0] prod_t;

endpackage

`default_nettype wire

/* booth_pp_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module booth_pp_gen import mul_pkg::*; (
    input  word_t      x,
    input  word_t      y,
    input  logic       mul_signed,
    output prod_t      pp [PP_ROWS]
);

    logic               x_ext_bit;
    logic               y_ext_bit;
    prod_t              ex_x;
    logic [XLEN+2:0]    ex_y;    // Two extension bits, the multiplier, a trailing zero.

    prod_t              pos_one;
    prod_t              pos_two;
    prod_t              neg_one;
    prod_t              neg_two;

    assign x_ext_bit = mul_signed & x[XLEN-1];
    assign y_ext_bit = mul_signed & y[XLEN-1];

    assign ex_x = {{XLEN{x_ext_bit}}, x};
    assign ex_y = {y_ext_bit, y_ext_bit, y, 1'b0};

    // The four nonzero multiples are shared by every row.
    assign pos_one = ex_x;
    assign pos_two = ex_x << 1;
    assign neg_one = -ex_x;
    assign neg_two = neg_one << 1;

    genvar j;
    generate
        for (j = 0; j < PP_ROWS; j = j + 1) begin : g_row
            logic [2:0] digit;
            logic       neg;
            logic       zero;
            logic       two;
            prod_t      multiple;

            assign digit = ex_y[2*j+2 : 2*j];

            // Recoding of one overlapping group of three multiplier bits.
            assign neg  = digit[2];
            assign zero = (digit == 3'b000) || (digit == 3'b111);
            assign two  = (digit == 3'b100) || (digit == 3'b011);

            always_comb begin
                if (zero) begin
                    multiple = '0;
                end else if (neg) begin
                    multiple = two ? neg_two : neg_one;
                end else begin
                    multiple = two ? pos_two : pos_one;
                end
            end

            // Row j carries the weight 4**j.
            assign pp[j] = multiple << (2 * j);
        end
    endgenerate

endmodule

`default_nettype wire

/* csa_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module csa_tree import mul_pkg::*; (
    input  prod_t pp [PP_ROWS],
    output prod_t sum
);

    // All fifteen 3:2 compressors of the tree share these arrays. Compressor k
    // takes csa_a/b/c[k] and produces csa_s[k] and the shifted carry csa_co[k].
    // The six levels use compressors 0 to 4, 5 to 8, 9 and 10, 11 and 12, 13 and 14.
    prod_t csa_a   [15];
    prod_t csa_b   [15];
    prod_t csa_c   [15];
    prod_t csa_s   [15];
    prod_t csa_maj [15];
    prod_t csa_co  [15];

    genvar k;
    generate
        for (k = 0; k < 15; k = k + 1) begin : g_csa
            assign csa_s[k]   = csa_a[k] ^ csa_b[k] ^ csa_c[k];
            assign csa_maj[k] = (csa_a[k] & csa_b[k]) | (csa_b[k] & csa_c[k])
                              | (csa_a[k] & csa_c[k]);
            // The carry moves one column up, so bit 0 is always clear.
            assign csa_co[k]  = {csa_maj[k][PLEN-2:0], 1'b0};
        end
    endgenerate

    // Level 1 compresses rows 0 to 14 in groups of three.
    assign csa_a[0] = pp[0];
    assign csa_b[0] = pp[1];
    assign csa_c[0] = pp[2];

    assign csa_a[1] = pp[3];
    assign csa_b[1] = pp[4];
    assign csa_c[1] = pp[5];

    assign csa_a[2] = pp[6];
    assign csa_b[2] = pp[7];
    assign csa_c[2] = pp[8];

    assign csa_a[3] = pp[9];
    assign csa_b[3] = pp[10];
    assign csa_c[3] = pp[11];

    assign csa_a[4] = pp[12];
    assign csa_b[4] = pp[13];
    assign csa_c[4] = pp[14];

    // Level 2. The last two Booth rows join the final level-1 carry here.
    assign csa_a[5] = csa_s[0];
    assign csa_b[5] = csa_co[0];
    assign csa_c[5] = csa_s[1];

    assign csa_a[6] = csa_co[1];
    assign csa_b[6] = csa_s[2];
    assign csa_c[6] = csa_co[2];

    assign csa_a[7] = csa_s[3];
    assign csa_b[7] = csa_co[3];
    assign csa_c[7] = csa_s[4];

    assign csa_a[8] = csa_co[4];
    assign csa_b[8] = pp[15];
    assign csa_c[8] = pp[16];

    // Level 3 leaves the outputs of compressor 8 waiting until level 4.
    assign csa_a[9]  = csa_s[5];
    assign csa_b[9]  = csa_co[5];
    assign csa_c[9]  = csa_s[6];

    assign csa_a[10] = csa_co[6];
    assign csa_b[10] = csa_s[7];
    assign csa_c[10] = csa_co[7];

    // Level 4.
    assign csa_a[11] = csa_s[9];
    assign csa_b[11] = csa_co[9];
    assign csa_c[11] = csa_s[10];

    assign csa_a[12] = csa_co[10];
    assign csa_b[12] = csa_s[8];
    assign csa_c[12] = csa_co[8];

    // Level 5.
    assign csa_a[13] = csa_s[11];
    assign csa_b[13] = csa_co[11];
    assign csa_c[13] = csa_s[12];

    // Level 6 brings the tree down to two rows.
    assign csa_a[14] = csa_co[12];
    assign csa_b[14] = csa_s[13];
    assign csa_c[14] = csa_co[13];

    // The carry-propagate add drops any overflow past bit 63.
    assign sum = csa_s[14] + csa_co[14];

endmodule

`default_nettype wire

/* mul_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_core import mul_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  en,
    input  word_t x,
    input  word_t y,
    input  logic  mul_signed,
    input  logic  use_high,
    output logic  mul_ok,
    output word_t result
);

    word_t rx;
    word_t ry;
    logic  r_signed;
    logic  r_high;
    logic  done;

    prod_t pp [PP_ROWS];
    prod_t product;

    // The request is captured on every enabled edge, so a held request is
    // simply recaptured with the same values.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx       <= '0;
            ry       <= '0;
            r_signed <= 1'b0;
            r_high   <= 1'b0;
        end else if (en) begin
            rx       <= x;
            ry       <= y;
            r_signed <= mul_signed;
            r_high   <= use_high;
        end
    end

    // Done alternates while enabled and drops on the first idle edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (en) begin
            done <= ~done;
        end else begin
            done <= 1'b0;
        end
    end

    booth_pp_gen u_booth_pp_gen (
        .x          (rx),
        .y          (ry),
        .mul_signed (r_signed),
        .pp         (pp)
    );

    csa_tree u_csa_tree (
        .pp  (pp),
        .sum (product)
    );

    assign mul_ok = done;
    assign result = r_high ? product[PLEN-1:XLEN] : product[XLEN-1:0];  // Half chosen at capture.

endmodule

`default_nettype wire

/* mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit import mul_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  slot0_valid,
    input  logic  slot0_high,
    input  logic  slot0_unsigned,
    input  word_t slot0_x,
    input  word_t slot0_y,
    input  logic  slot1_valid,
    input  logic  slot1_high,
    input  logic  slot1_unsigned,
    input  word_t slot1_x,
    input  word_t slot1_y,
    input  logic  flush,
    output logic  mul_ok,
    output word_t result
);

    logic  sel_valid;
    logic  sel_high;
    logic  sel_unsigned;
    word_t sel_x;
    word_t sel_y;

    // Slot 0 always wins. With no request the core sees zeros.
    always_comb begin
        sel_valid    = 1'b0;
        sel_high     = 1'b0;
        sel_unsigned = 1'b0;
        sel_x        = '0;
        sel_y        = '0;
        if (slot0_valid) begin
            sel_valid    = 1'b1;
            sel_high     = slot0_high;
            sel_unsigned = slot0_unsigned;
            sel_x        = slot0_x;
            sel_y        = slot0_y;
        end else if (slot1_valid) begin
            sel_valid    = 1'b1;
            sel_high     = slot1_high;
            sel_unsigned = slot1_unsigned;
            sel_x        = slot1_x;
            sel_y        = slot1_y;
        end
    end

    mul_core u_mul_core (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (sel_valid & ~flush),    // A flushed request never reaches the core.
        .x          (sel_x),
        .y          (sel_y),
        .mul_signed (~sel_unsigned),
        .use_high   (sel_high),
        .mul_ok     (mul_ok),
        .result     (result)
    );

endmodule

`default_nettype wire

/* mul_unit_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit_assertions import mul_pkg::*; (
    input logic  clk,
    input logic  arst_n,
    input logic  en,
    input word_t x,
    input word_t y,
    input logic  mul_signed,
    input logic  use_high,
    input logic  mul_ok,
    input word_t result
);

    logic [2*XLEN+1:0] req;

    assign req = {x, y, mul_signed, use_high};  // Everything the core captures.

    // Done is a toggle, so it can never stay high across an edge.
    property ok_never_twice;
        @(posedge clk) disable iff (!arst_n)
            mul_ok |=> !mul_ok;
    endproperty

    property idle_edge_clears_ok;
        @(posedge clk) disable iff (!arst_n)
            !en |=> !mul_ok;
    endproperty

    // A held request gives the same word on the next high phase.
    property result_repeats;
        @(posedge clk) disable iff (!arst_n)
            (mul_ok && en && $stable(req)) ##1 (en && $stable(req))
            |=> (mul_ok && result == $past(result, 2));
    endproperty

    a_ok_never_twice: assert property (ok_never_twice)
        else $error("mul_ok was high in two consecutive cycles");

    a_idle_edge_clears_ok: assert property (idle_edge_clears_ok)
        else $error("mul_ok high after an edge with en low");

    a_result_repeats: assert property (result_repeats)
        else $error("result changed between high phases of a held request");

endmodule

`default_nettype wire

/* tb_mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mul_unit import mul_pkg::*; ();

    localparam int N_RANDOM   = 300;
    localparam int MAX_ROWS   = 340;
    localparam int WAIT_LIMIT = 16;

    logic  clk;
    logic  arst_n;
    logic  slot0_valid;
    logic  slot0_high;
    logic  slot0_unsigned;
    word_t slot0_x;
    word_t slot0_y;
    logic  slot1_valid;
    logic  slot1_high;
    logic  slot1_unsigned;
    word_t slot1_x;
    word_t slot1_y;
    logic  flush;
    logic  mul_ok;
    word_t result;

    // Stimulus table. One row holds both slots, the flush bit and the expected word.
    logic  t_s0_valid [MAX_ROWS];
    logic  t_s0_high  [MAX_ROWS];
    logic  t_s0_uns   [MAX_ROWS];
    word_t t_s0_x     [MAX_ROWS];
    word_t t_s0_y     [MAX_ROWS];
    logic  t_s1_valid [MAX_ROWS];
    logic  t_s1_high  [MAX_ROWS];
    logic  t_s1_uns   [MAX_ROWS];
    word_t t_s1_x     [MAX_ROWS];
    word_t t_s1_y     [MAX_ROWS];
    logic  t_flush    [MAX_ROWS];
    word_t t_expect   [MAX_ROWS];
    int    n_rows;

    logic [31:0] lcg_state;
    int          checks;
    int          value_errors;
    int          timeouts;

    mul_unit u_mul_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .slot0_valid    (slot0_valid),
        .slot0_high     (slot0_high),
        .slot0_unsigned (slot0_unsigned),
        .slot0_x        (slot0_x),
        .slot0_y        (slot0_y),
        .slot1_valid    (slot1_valid),
        .slot1_high     (slot1_high),
        .slot1_unsigned (slot1_unsigned),
        .slot1_x        (slot1_x),
        .slot1_y        (slot1_y),
        .flush          (flush),
        .mul_ok         (mul_ok),
        .result         (result)
    );

    bind mul_core mul_unit_assertions u_mul_unit_assertions (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .x          (x),
        .y          (y),
        .mul_signed (mul_signed),
        .use_high   (use_high),
        .mul_ok     (mul_ok),
        .result     (result)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Reference product. Both operands are widened per the unsigned flag first.
    function automatic word_t expected_word(word_t a, word_t b, logic uns, logic high);
        prod_t wa;
        prod_t wb;
        prod_t p;
        wa = uns ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
        wb = uns ? {{XLEN{1'b0}}, b} : {{XLEN{b[XLEN-1]}}, b};
        p  = wa * wb;
        return high ? p[PLEN-1:XLEN] : p[XLEN-1:0];
    endfunction

    task automatic add_row(input logic v0, input logic h0, input logic u0,
                           input word_t x0, input word_t y0,
                           input logic v1, input logic h1, input logic u1,
                           input word_t x1, input word_t y1, input logic fl);
        t_s0_valid[n_rows] = v0;
        t_s0_high[n_rows]  = h0;
        t_s0_uns[n_rows]   = u0;
        t_s0_x[n_rows]     = x0;
        t_s0_y[n_rows]     = y0;
        t_s1_valid[n_rows] = v1;
        t_s1_high[n_rows]  = h1;
        t_s1_uns[n_rows]   = u1;
        t_s1_x[n_rows]     = x1;
        t_s1_y[n_rows]     = y1;
        t_flush[n_rows]    = fl;
        // Slot 0 has priority whenever it is valid.
        t_expect[n_rows]   = v0 ? expected_word(x0, y0, u0, h0) : expected_word(x1, y1, u1, h1);
        n_rows++;
    endtask

    task automatic add_slot0(input logic h, input logic u, input word_t a, input word_t b);
        add_row(1'b1, h, u, a, b, 1'b0, 1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic add_slot1(input logic h, input logic u, input word_t a, input word_t b);
        add_row(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, h, u, a, b, 1'b0);
    endtask

    task automatic build_table();
        logic [31:0] ctl;
        word_t       a0;
        word_t       b0;
        word_t       a1;
        word_t       b1;
        n_rows = 0;
        add_slot0(1'b0, 1'b0, 32'd3, 32'd5);
        add_slot0(1'b0, 1'b0, 32'hffff_fffd, 32'd5);
        add_slot0(1'b1, 1'b0, 32'hffff_fffd, 32'd5);
        add_slot0(1'b0, 1'b0, 32'hffff_fff9, 32'hffff_fff7);
        add_slot0(1'b1, 1'b0, 32'hffff_fff9, 32'hffff_fff7);
        add_slot0(1'b1, 1'b0, 32'h8000_0000, 32'h8000_0000);
        add_slot0(1'b0, 1'b0, 32'h8000_0000, 32'h8000_0000);
        add_slot0(1'b1, 1'b0, 32'h8000_0000, 32'hffff_ffff);
        add_slot0(1'b0, 1'b0, 32'h8000_0000, 32'hffff_ffff);
        add_slot0(1'b0, 1'b0, 32'h0000_0000, 32'hffff_ffff);
        add_slot0(1'b1, 1'b0, 32'h0000_0000, 32'h8000_0000);
        add_slot0(1'b1, 1'b0, 32'hdead_beef, 32'hcafe_babe);
        add_slot0(1'b1, 1'b1, 32'hffff_ffff, 32'hffff_ffff);
        add_slot0(1'b1, 1'b1, 32'h8000_0000, 32'h0000_0002);
        add_slot0(1'b1, 1'b0, 32'h8000_0000, 32'h0000_0002);
        add_slot0(1'b1, 1'b1, 32'h8000_0001, 32'hc000_0000);
        add_row(1'b1, 1'b0, 1'b0, 32'd7, 32'd9,
                1'b1, 1'b1, 1'b1, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
        add_slot1(1'b1, 1'b1, 32'hffff_ffff, 32'hffff_ffff);
        add_slot1(1'b0, 1'b0, 32'h1234_5678, 32'h9abc_def0);
        add_row(1'b1, 1'b0, 1'b0, 32'd6, 32'd7, 1'b0, 1'b0, 1'b0, '0, '0, 1'b1);
        add_row(1'b0, 1'b0, 1'b0, '0, '0, 1'b1, 1'b1, 1'b0, 32'd11, 32'd13, 1'b1);
        for (int k = 0; k < N_RANDOM; k++) begin
            ctl = next_rand();
            a0  = next_rand();
            b0  = next_rand();
            a1  = next_rand();
            b1  = next_rand();
            // Upper LCG bits are the better random ones.
            add_row(ctl[20] | ctl[21], ctl[22], ctl[23], a0, b0,
                    1'b1, ctl[24], ctl[25], a1, b1, 1'b0);
        end
    endtask

    task automatic clear_inputs();
        slot0_valid    = 1'b0;
        slot0_high     = 1'b0;
        slot0_unsigned = 1'b0;
        slot0_x        = '0;
        slot0_y        = '0;
        slot1_valid    = 1'b0;
        slot1_high     = 1'b0;
        slot1_unsigned = 1'b0;
        slot1_x        = '0;
        slot1_y        = '0;
        flush          = 1'b0;
    endtask

    task automatic drive_row(input int i);
        slot0_valid    = t_s0_valid[i];
        slot0_high     = t_s0_high[i];
        slot0_unsigned = t_s0_uns[i];
        slot0_x        = t_s0_x[i];
        slot0_y        = t_s0_y[i];
        slot1_valid    = t_s1_valid[i];
        slot1_high     = t_s1_high[i];
        slot1_unsigned = t_s1_uns[i];
        slot1_x        = t_s1_x[i];
        slot1_y        = t_s1_y[i];
        flush          = t_flush[i];
    endtask

    task automatic wait_for_ok(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mul_ok && cycles < WAIT_LIMIT);
    endtask

    task automatic check_low(input string what);
        checks++;
        if (mul_ok !== 1'b0) begin
            value_errors++;
            $display("[ERROR] t=%0d ns: mul_ok high %s", $time, what);
        end
    endtask

    // Called at a falling edge. Leaves the inputs idle for one full cycle.
    task automatic run_row(input int i);
        int    cycles;
        word_t first;
        drive_row(i);
        if (t_flush[i]) begin
            repeat (2) begin
                @(negedge clk);
                check_low($sformatf("for flushed row %0d", i));
            end
        end else begin
            wait_for_ok(cycles);
            if (mul_ok !== 1'b1) begin
                timeouts++;
                $display("Timeout: row %0d got no mul_ok within %0d cycles", i, WAIT_LIMIT);
            end else begin
                checks += 2;
                if (cycles != 1) begin
                    value_errors++;
                    $display("[ERROR] t=%0d ns: row %0d latency %0d, expected 1", $time, i, cycles);
                end
                if (result !== t_expect[i]) begin
                    value_errors++;
                    $display("[ERROR] t=%0d ns: row %0d result %h, expected %h",
                             $time, i, result, t_expect[i]);
                end
                first = result;
                @(negedge clk);
                check_low($sformatf("in the off phase of row %0d", i));
                @(negedge clk);
                checks++;
                if (mul_ok !== 1'b1 || result !== first) begin
                    value_errors++;
                    $display("[ERROR] t=%0d ns: row %0d repeat gave mul_ok %b result %h",
                             $time, i, mul_ok, result);
                end
            end
        end
        clear_inputs();
        @(negedge clk);
    endtask

    // Flush arrives in the low phase, where done would otherwise rise.
    task automatic flush_while_toggling();
        int cycles;
        slot0_valid = 1'b1;
        slot0_x     = 32'd1234;
        slot0_y     = 32'd5678;
        wait_for_ok(cycles);
        if (mul_ok !== 1'b1) begin
            timeouts++;
            $display("Timeout: the request before the flush got no mul_ok");
        end else begin
            @(negedge clk);
            flush = 1'b1;
            repeat (2) begin
                @(negedge clk);
                check_low("after flush during toggling");
            end
        end
        clear_inputs();
        @(negedge clk);
    endtask

    initial begin
        lcg_state    = 32'h0fd5_1f9e;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        arst_n       = 1'b0;
        clear_inputs();
        build_table();
        repeat (10) @(negedge clk);
        check_low("during reset");
        arst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_low("after reset with no request");
        end
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        flush_while_toggling();
        $display("Rows %0d, checks %0d, value errors %0d, timeouts %0d",
                 n_rows, checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mul_unit.f */
mul_pkg.sv
booth_pp_gen.sv
csa_tree.sv
mul_core.sv
mul_unit.sv
mul_unit_assertions.sv
tb_mul_unit.sv

/* Bender.yml */
package:
  name: mul_unit

sources:
  - files:
      - mul_pkg.sv
      - booth_pp_gen.sv
      - csa_tree.sv
      - mul_core.sv
      - mul_unit.sv
  - target: test
    files:
      - mul_unit_assertions.sv
      - tb_mul_unit.sv
